// ==== include/wb_arb_model.svh ====
// Reference model for the Wishbone arbitration testbench
// Stimulus LFSR, cycle-by-cycle grant prediction and a shadow memory
`ifndef WB_ARB_MODEL_SVH
`define WB_ARB_MODEL_SVH

// Model state, PN kept as {s3, s2, s1}
logic [2:0]           model_pn;
arb_pkg::master_idx_t model_last;
arb_pkg::grant_t      model_grant;
arb_pkg::wb_data_t    model_mem [arb_pkg::mem_words];

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] galois_next(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 16'hb400;
  end
  return n;
endfunction

function automatic logic [2:0] pn_next(input logic [2:0] s);
  return {s[1], s[0], s[0] ^ s[2]};
endfunction

function automatic arb_pkg::grant_t model_pick(
  input arb_pkg::grant_t      req,
  input arb_pkg::master_idx_t start,
  input logic                 wrap
);
  arb_pkg::grant_t      g;
  arb_pkg::master_idx_t idx;
  g = '0;
  if (req[start]) begin
    g[start] = 1'b1;
    return g;
  end
  for (int k = 0; k < arb_pkg::num_masters; k++) begin
    // Fixed and random go ascending from 0, round robin wraps from start
    idx = wrap ? start + arb_pkg::master_idx_t'(k) : arb_pkg::master_idx_t'(k);
    if (req[idx]) begin
      g[idx] = 1'b1;
      return g;
    end
  end
  return g;
endfunction

function automatic arb_pkg::grant_t model_choice(
  input arb_pkg::arb_mode_t mode,
  input arb_pkg::grant_t    req
);
  case (mode)
    arb_pkg::arb_fixed0, arb_pkg::arb_fixed1,
    arb_pkg::arb_fixed2, arb_pkg::arb_fixed3:
      return model_pick(req, arb_pkg::master_idx_t'(mode), 1'b0);
    arb_pkg::arb_round_robin:
      return model_pick(req, model_last + 2'd1, 1'b1);
    arb_pkg::arb_random:
      return model_pick(req, model_pn[2:1], 1'b0);
    default:
      return '0;
  endcase
endfunction

task automatic model_reset();
  model_pn    = 3'b001;
  model_last  = '0;
  model_grant = '0;
  for (int i = 0; i < arb_pkg::mem_words; i++) begin
    model_mem[i] = '0;
  end
endtask

// One rising edge of the grant register
task automatic model_clock(input arb_pkg::arb_mode_t mode, input arb_pkg::grant_t req);
  arb_pkg::grant_t pick;
  pick = model_choice(mode, req);
  if ((model_grant & req) == '0) begin
    model_grant = pick;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      if (pick[i]) begin
        model_last = arb_pkg::master_idx_t'(i);
      end
    end
  end
  model_pn = pn_next(model_pn);
endtask

`endif

// ==== dv/tb_wb_arb_top.sv ====
`timescale 1ns/1ps
// Testbench for the shared Wishbone bus with four random masters
// Grant and read data are checked every cycle against the reference model
module tb_wb_arb_top;

  `include "wb_arb_model.svh"

  localparam int clk_period = 8;
  localparam int test_cycles = 200;
  localparam int drain_limit = 64;
  localparam int off_cycles = 30;
  // Reset, four fixed modes, round robin, random, then the no-grant phases
  localparam int total_cycles = 17 + 6 * test_cycles + 2 * drain_limit + 2 * off_cycles;

  logic                   clk;
  logic                   rst_n;
  arb_pkg::arb_mode_t     arb_type;
  arb_pkg::wb_req_array_t m_req;
  arb_pkg::wb_rsp_array_t m_rsp;
  arb_pkg::grant_t        grant;

  // Stimulus and bookkeeping
  logic [15:0]            lfsr;
  arb_pkg::arb_mode_t     mode_sel;
  arb_pkg::arb_mode_t     prev_mode;
  arb_pkg::wb_req_array_t nxt_req;
  arb_pkg::grant_t        prev_grant;
  arb_pkg::grant_t        prev_req;
  arb_pkg::master_idx_t   rr_owner;
  logic                   rr_valid;
  logic                   busy [arb_pkg::num_masters];
  logic                   reached [arb_pkg::num_masters];
  int                     reach_cycle [arb_pkg::num_masters];
  int                     start_mode;
  int                     cycle_cnt;
  int                     rr_checks;
  int                     checks;
  int                     errors;
  int                     test_errors;
  int                     tests_run;
  int                     tests_failed;
  string                  cur_test;

  wb_arb_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .m_req    (m_req),
    .m_rsp    (m_rsp),
    .grant    (grant)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // One bit per LFSR step
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
    end
    $display("%s: done, %0d errors", cur_test, errors - test_errors);
  endtask

  // Check at the falling edge, step the model, drive at the next rising edge
  task automatic step_cycle();
    arb_pkg::grant_t      req_now;
    arb_pkg::grant_t      ack_now;
    arb_pkg::master_idx_t new_idx;
    @(negedge clk);
    cycle_cnt++;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      req_now[i] = m_req[i].cyc;
      ack_now[i] = m_rsp[i].ack;
    end
    check_value("grant", model_grant, grant);
    if ((prev_grant & prev_req) != '0) begin
      check_value("held grant", prev_grant, grant);
    end else if (grant != '0) begin
      new_idx = '0;
      for (int i = 0; i < arb_pkg::num_masters; i++) begin
        if (grant[i]) begin
          new_idx = arb_pkg::master_idx_t'(i);
        end
      end
      // Rotation is only defined when every other master was waiting
      if (prev_mode == arb_pkg::arb_round_robin && rr_valid &&
          (prev_req | (4'b0001 << rr_owner)) == 4'b1111) begin
        check_value("round robin owner", arb_pkg::master_idx_t'(rr_owner + 1), new_idx);
        rr_checks++;
      end
      rr_owner = new_idx;
      rr_valid = 1'b1;
    end
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      // A waiting master sees no read data
      if (!model_grant[i]) begin
        check_value($sformatf("idle data m%0d", i), 0, m_rsp[i].dat);
      end
      if (ack_now[i]) begin
        check_value($sformatf("ack to owner m%0d", i), 1, grant[i]);
        if (!busy[i] || !reached[i]) begin
          report_failure($sformatf("master %0d got an ack with no cycle on the bus", i));
        end else begin
          check_value($sformatf("ack latency m%0d", i), 1, cycle_cnt - reach_cycle[i]);
          if (nxt_req[i].we) begin
            model_mem[nxt_req[i].adr] = nxt_req[i].dat;
          end else begin
            check_value($sformatf("read data m%0d", i), model_mem[nxt_req[i].adr],
                        m_rsp[i].dat);
          end
        end
        busy[i] = 1'b0;
        nxt_req[i] = '0;
      end else if (busy[i] && grant[i] && !reached[i]) begin
        reached[i] = 1'b1;
        reach_cycle[i] = cycle_cnt;
      end else if (!busy[i] && (start_mode == 2 || (start_mode == 1 && take_bits(2) == 0))) begin
        busy[i] = 1'b1;
        reached[i] = 1'b0;
        nxt_req[i].cyc = 1'b1;
        nxt_req[i].stb = 1'b1;
        nxt_req[i].we = 1'(take_bits(1));
        nxt_req[i].adr = arb_pkg::wb_addr_t'(take_bits(4));
        nxt_req[i].dat = take_bits(32);
      end
    end
    model_clock(arb_type, req_now);
    prev_grant = grant;
    prev_req = req_now;
    prev_mode = arb_type;
    @(posedge clk);
    arb_type <= mode_sel;
    m_req <= nxt_req;
  endtask

  task automatic run_cycles(input int n, input int mode_of_start);
    start_mode = mode_of_start;
    repeat (n) begin
      step_cycle();
    end
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      if (busy[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // Stop new cycles and let the open ones finish
  task automatic drain();
    int n;
    n = 0;
    start_mode = 0;
    while (pending_count() != 0 && n < drain_limit) begin
      step_cycle();
      n++;
    end
    if (pending_count() != 0) begin
      report_failure($sformatf("pending bus cycles did not complete in %0d cycles", drain_limit));
    end
  endtask

  initial begin
    #(total_cycles * clk_period + 50 * clk_period);
    $display("Watchdog expired: the run did not finish in the expected time");
    $display("test failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    arb_type = arb_pkg::arb_fixed0;
    m_req = '0;
    mode_sel = arb_pkg::arb_fixed0;
    prev_mode = arb_pkg::arb_fixed0;
    nxt_req = '0;
    prev_grant = '0;
    prev_req = '0;
    rr_owner = '0;
    rr_valid = 1'b0;
    lfsr = 16'd53936;
    cycle_cnt = 0;
    rr_checks = 0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      busy[i] = 1'b0;
      reached[i] = 1'b0;
      reach_cycle[i] = 0;
    end
    model_reset();

    begin_test("reset");
    repeat (16) begin
      @(negedge clk);
      check_value("grant in reset", 0, grant);
      for (int i = 0; i < arb_pkg::num_masters; i++) begin
        check_value($sformatf("ack m%0d in reset", i), 0, m_rsp[i].ack);
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    run_cycles(1, 0);
    end_test();

    for (int m = 0; m < 4; m++) begin
      begin_test($sformatf("fixed%0d", m));
      mode_sel = arb_pkg::arb_mode_t'(m);
      run_cycles(test_cycles, 1);
      end_test();
    end

    // Masters restart at once, so all four keep requesting
    begin_test("round_robin");
    mode_sel = arb_pkg::arb_round_robin;
    rr_checks = 0;
    run_cycles(test_cycles, 2);
    if (rr_checks == 0) begin
      report_failure("round robin rotation was never seen with all masters requesting");
    end
    end_test();

    begin_test("random");
    mode_sel = arb_pkg::arb_random;
    run_cycles(test_cycles, 1);
    end_test();

    begin_test("no_grant");
    drain();
    mode_sel = arb_pkg::arb_mode_t'(3'd6);
    run_cycles(off_cycles, 1);
    mode_sel = arb_pkg::arb_mode_t'(3'd7);
    run_cycles(off_cycles, 1);
    if (pending_count() == 0) begin
      report_failure("no master was left waiting while the bus granted nobody");
    end
    mode_sel = arb_pkg::arb_fixed2;
    drain();
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== logic/arb_pkg.sv ====
// Shared types for the four-master Wishbone classic arbitration subsystem
// Request and response structs, grant vectors and arbitration modes
package arb_pkg;

  localparam int num_masters = 4;
  localparam int mem_words = 16;

  // Word address into the register memory
  typedef logic [3:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // One-hot owner, all zero when the bus is idle
  typedef logic [num_masters-1:0] grant_t;
  typedef logic [1:0] master_idx_t;

  // Codes 6 and 7 are left unnamed and grant nobody
  typedef enum logic [2:0] {
    arb_fixed0      = 3'd0,
    arb_fixed1      = 3'd1,
    arb_fixed2      = 3'd2,
    arb_fixed3      = 3'd3,
    arb_round_robin = 3'd4,
    arb_random      = 3'd5
  } arb_mode_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  // Index i carries master i
  typedef wb_req_t [num_masters-1:0] wb_req_array_t;
  typedef wb_rsp_t [num_masters-1:0] wb_rsp_array_t;

endpackage

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps
// Four-master bus arbiter with fixed, round-robin and random schemes
// The registered grant stays with its owner while that owner keeps cyc high
module bus_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::arb_mode_t arb_type,
  input  arb_pkg::grant_t    req,
  output arb_pkg::grant_t    grant
);

  arb_pkg::master_idx_t rand_idx;
  arb_pkg::master_idx_t last_idx;
  arb_pkg::grant_t      gnt_fixed [arb_pkg::num_masters];
  arb_pkg::grant_t      gnt_rr;
  arb_pkg::grant_t      gnt_rand;
  arb_pkg::grant_t      choice;
  logic                 hold;

  // Named master first, then the rest in ascending order
  function automatic arb_pkg::grant_t first_then_ascending(
    input arb_pkg::grant_t      req_vec,
    input arb_pkg::master_idx_t first
  );
    arb_pkg::grant_t pick;
    logic            found;
    pick  = '0;
    found = 1'b0;
    if (req_vec[first]) begin
      pick[first] = 1'b1;
      found       = 1'b1;
    end
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      if (!found && req_vec[i]) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  // Search from one above the last owner, wrapping around
  function automatic arb_pkg::grant_t rotate_pick(
    input arb_pkg::grant_t      req_vec,
    input arb_pkg::master_idx_t last
  );
    arb_pkg::grant_t      pick;
    arb_pkg::master_idx_t idx;
    logic                 found;
    pick  = '0;
    found = 1'b0;
    for (int k = 1; k <= arb_pkg::num_masters; k++) begin
      idx = last + arb_pkg::master_idx_t'(k);
      if (!found && req_vec[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic arb_pkg::master_idx_t onehot_to_idx(input arb_pkg::grant_t g);
    arb_pkg::master_idx_t idx;
    idx = '0;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      if (g[i]) begin
        idx = arb_pkg::master_idx_t'(i);
      end
    end
    return idx;
  endfunction

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  // All six candidate grants evaluated in parallel
  for (genvar n = 0; n < arb_pkg::num_masters; n++) begin : g_fixed
    assign gnt_fixed[n] = first_then_ascending(req, arb_pkg::master_idx_t'(n));
  end

  assign gnt_rr   = rotate_pick(req, last_idx);
  assign gnt_rand = first_then_ascending(req, rand_idx);

  always_comb begin
    case (arb_type)
      arb_pkg::arb_fixed0:      choice = gnt_fixed[0];
      arb_pkg::arb_fixed1:      choice = gnt_fixed[1];
      arb_pkg::arb_fixed2:      choice = gnt_fixed[2];
      arb_pkg::arb_fixed3:      choice = gnt_fixed[3];
      arb_pkg::arb_round_robin: choice = gnt_rr;
      arb_pkg::arb_random:      choice = gnt_rand;
      default:                  choice = '0;
    endcase
  end

  // Bus lock: owner still has cyc up
  assign hold = |(grant & req);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant    <= '0;
      last_idx <= '0;
    end else if (!hold) begin
      grant <= choice;
      // Round-robin pointer only moves on a real owner
      if (|choice) begin
        last_idx <= onehot_to_idx(choice);
      end
    end
  end

  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant)
  );

  a_grant_requested: assert property (
    @(posedge clk) disable iff (!rst_n)
    (grant != '0) |-> |(grant & $past(req))
  );

  a_grant_locked: assert property (
    @(posedge clk) disable iff (!rst_n)
    |(grant & req) |=> (grant == $past(grant))
  );

endmodule

// ==== logic/pn_seq_gen.sv ====
`timescale 1ns/1ps
// 3-bit Fibonacci PN sequence generator with a period of 7
// The two oldest stages give the random first-priority master index
module pn_seq_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  output arb_pkg::master_idx_t rand_idx
);

  logic s1;
  logic s2;
  logic s3;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      // Feedback from newest and oldest stage
      s1 <= s1 ^ s3;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};

  // All-zero is the lock-up state of the xor feedback
  a_state_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) (|{s3, s2, s1})
  );

endmodule

// ==== logic/wb_arb_top.sv ====
`timescale 1ns/1ps
// Shared Wishbone classic bus with four masters and one register memory
// Connects the arbiter, the master mux and the slave
module wb_arb_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  arb_pkg::arb_mode_t     arb_type,
  input  arb_pkg::wb_req_array_t m_req,
  output arb_pkg::wb_rsp_array_t m_rsp,
  output arb_pkg::grant_t        grant
);

  arb_pkg::grant_t  req_vec;
  arb_pkg::wb_req_t s_req;
  arb_pkg::wb_rsp_t s_rsp;

  // Each master's cyc is its bus request
  for (genvar i = 0; i < arb_pkg::num_masters; i++) begin : g_cyc
    assign req_vec[i] = m_req[i].cyc;
  end

  bus_arbiter u_bus_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .req      (req_vec),
    .grant    (grant)
  );

  wb_master_mux u_wb_master_mux (
    .grant (grant),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  wb_reg_mem u_wb_reg_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (s_req),
    .rsp   (s_rsp)
  );

endmodule

// ==== logic/wb_master_mux.sv ====
`timescale 1ns/1ps
// Wishbone request mux and response fan-out for the shared slave
// Only the granted master reaches the slave and sees its response
module wb_master_mux (
  input  arb_pkg::grant_t        grant,
  input  arb_pkg::wb_req_array_t m_req,
  output arb_pkg::wb_rsp_array_t m_rsp,
  output arb_pkg::wb_req_t       s_req,
  input  arb_pkg::wb_rsp_t       s_rsp
);

  arb_pkg::grant_t cyc_vec;

  // AND-OR select, all zero with no owner
  always_comb begin
    s_req = '0;
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      s_req = s_req | (m_req[i] & {$bits(arb_pkg::wb_req_t){grant[i]}});
    end
  end

  // Masters without the grant see a quiet bus and wait
  always_comb begin
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      if (grant[i]) begin
        m_rsp[i] = s_rsp;
      end else begin
        m_rsp[i] = '0;
      end
    end
  end

  // Open bus cycles, one bit per master
  always_comb begin
    for (int i = 0; i < arb_pkg::num_masters; i++) begin
      cyc_vec[i] = m_req[i].cyc;
    end
  end

  // A slave ack always lands on an owner that still holds its cycle open
  a_ack_to_owner: assert final (
    $isunknown({grant, s_rsp.ack}) || !s_rsp.ack || ((grant & cyc_vec) != '0)
  );

endmodule

// ==== logic/wb_reg_mem.sv ====
`timescale 1ns/1ps
// Wishbone classic slave holding a 16-word by 32-bit register memory
// Each strobe gets one registered ack, with read data returned alongside
module wb_reg_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  arb_pkg::wb_req_t req,
  output arb_pkg::wb_rsp_t rsp
);

  arb_pkg::wb_data_t mem [arb_pkg::mem_words];
  arb_pkg::wb_data_t rd_data;
  logic              ack;
  logic              access;

  // New strobe not yet acknowledged
  assign access = req.cyc && req.stb && !ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      rd_data <= '0;
      for (int i = 0; i < arb_pkg::mem_words; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack <= access;
      // Write lands on the same edge that raises ack
      if (access && req.we) begin
        mem[req.adr] <= req.dat;
      end
      if (access && !req.we) begin
        rd_data <= mem[req.adr];
      end
    end
  end

  assign rsp = '{ack: ack, dat: rd_data};

  // Single-cycle ack that always follows a live strobe
  a_ack_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp.ack |-> ($past(req.cyc && req.stb) && !$past(rsp.ack))
  );

endmodule

// ==== sim.f ====
+incdir+include
logic/arb_pkg.sv
logic/pn_seq_gen.sv
logic/bus_arbiter.sv
logic/wb_master_mux.sv
logic/wb_reg_mem.sv
logic/wb_arb_top.sv
dv/tb_wb_arb_top.sv
